/* hw/axi_ctrl_settings.svh */
// Bus widths, region map and sizes of the AXI4 register controller
`ifndef AXI_CTRL_SETTINGS_SVH
`define AXI_CTRL_SETTINGS_SVH

`define AXI_DATA_W      8               // Byte-wide peripheral
`define AXI_ADDR_W      32
`define AXI_ID_W        5               // Master ID
`define AXI_LEN_W       8               // AxLEN field

`define CONF_BASE       32'h2000_0000   // Config registers, read/write
`define STAT_BASE       32'h2400_0000   // Status bytes, read-only
`define WST_BASE        32'h2100_0000   // Write-stream FIFOs

`define CONF_REG_NUM    8
`define STAT_REG_NUM    8
`define WST_FIFO_NUM    2
`define WST_FIFO_DEPTH  4               // Power of two

`endif

/* hw/axi_ctrl_pkg.sv */
// Burst and response codes plus the AXI channel payload structs
`default_nettype none
`include "axi_ctrl_settings.svh"

package axi_ctrl_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11    // No region matched
    } resp_e;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        burst_e                 burst;
    } aw_req_t;                // 39 bits, no AWLEN since W carries last

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic                   last;
    } w_beat_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        burst_e                 burst;
        logic [`AXI_LEN_W-1:0]  len;
    } ar_req_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        resp_e                  resp;
    } b_resp_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        resp_e                  resp;
        logic                   last;
    } r_beat_t;

endpackage

`default_nettype wire

/* hw/chan_skid_buf.sv */
// Fully registered two-entry skid buffer for one valid/ready channel
`timescale 1ns/10ps
`default_nettype none

module chan_skid_buf #(
    parameter type payload_t = axi_ctrl_pkg::w_beat_t
) (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       payload_t in_data_i,
    input  wire       in_valid_i,
    output logic      in_ready_o,
    output payload_t  out_data_o,
    output logic      out_valid_o,
    input  wire       out_ready_i
);
    logic     out_valid_q;     // Main entry occupied
    logic     skid_valid_q;    // Overflow entry occupied
    logic     in_ready_q;      // Registered, low in reset and when skid full
    payload_t skid_data_q;
    logic     out_take;
    logic     in_take;

    assign out_take    = out_ready_i | ~out_valid_q;    // Main entry can load
    assign in_take     = in_valid_i & in_ready_q;
    assign in_ready_o  = in_ready_q;
    assign out_valid_o = out_valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
            in_ready_q   <= 1'b0;
        end else if (out_take) begin
            out_valid_q  <= skid_valid_q | in_take;    // Skid drains first
            skid_valid_q <= 1'b0;
            in_ready_q   <= 1'b1;
        end else if (in_take) begin
            skid_valid_q <= 1'b1;    // Output stalled, park the beat
            in_ready_q   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (out_take) begin
            out_data_o <= skid_valid_q ? skid_data_q : in_data_i;
        end
        if (in_take && !out_take) begin
            skid_data_q <= in_data_i;
        end
    end

endmodule

`default_nettype wire

/* hw/wr_stream_fifo.sv */
// Write-stream FIFO with fill count, drained by an outside consumer
`timescale 1ns/10ps
`default_nettype none
`include "axi_ctrl_settings.svh"

module wr_stream_fifo #(
    parameter int DEPTH = 4
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     push_i,
    input  wire [`AXI_DATA_W-1:0]   push_data_i,
    output logic                    full_o,
    output logic [`AXI_DATA_W-1:0]  pop_data_o,
    output logic                    pop_valid_o,
    input  wire                     pop_ready_i,
    output logic [$clog2(DEPTH):0]  count_o
);
    localparam int PTR_W = $clog2(DEPTH);

    logic [`AXI_DATA_W-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]       wr_ptr_q;     // Wraps naturally, DEPTH is a power of two
    logic [PTR_W-1:0]       rd_ptr_q;
    logic [PTR_W:0]         count_q;
    logic                   push_ok;
    logic                   pop_ok;

    assign full_o      = (count_q == (PTR_W+1)'(DEPTH));
    assign pop_valid_o = |count_q;          // Valid whenever not empty
    assign pop_data_o  = mem_q[rd_ptr_q];
    assign count_o     = count_q;
    assign push_ok     = push_i & ~full_o;
    assign pop_ok      = pop_valid_o & pop_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PTR_W+1)'(push_ok) - (PTR_W+1)'(pop_ok);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

/* hw/axi_write_path.sv */
// Write path: beat addressing, config register writes, FIFO pushes and B response
`timescale 1ns/10ps
`default_nettype none
`include "axi_ctrl_settings.svh"

module axi_write_path (
    input  wire                                             clk,
    input  wire                                             rst_n,
    input  wire axi_ctrl_pkg::aw_req_t                      aw_i,
    input  wire                                             aw_valid_i,
    output logic                                            aw_ready_o,
    input  wire axi_ctrl_pkg::w_beat_t                      w_i,
    input  wire                                             w_valid_i,
    output logic                                            w_ready_o,
    output axi_ctrl_pkg::b_resp_t                           b_o,
    output logic                                            b_valid_o,
    input  wire                                             b_ready_i,
    output logic [`CONF_REG_NUM-1:0][`AXI_DATA_W-1:0]       conf_reg_o,
    output logic [`WST_FIFO_NUM-1:0][$clog2(`WST_FIFO_DEPTH):0] wst_count_o,
    output logic [`WST_FIFO_NUM-1:0][`AXI_DATA_W-1:0]       wst_data_o,
    output logic [`WST_FIFO_NUM-1:0]                        wst_valid_o,
    input  wire  [`WST_FIFO_NUM-1:0]                        wst_ready_i
);
    import axi_ctrl_pkg::*;

    localparam int CONF_IDX_W = $clog2(`CONF_REG_NUM);
    localparam int WST_IDX_W  = $clog2(`WST_FIFO_NUM);

    logic [`AXI_LEN_W-1:0]   beat_cnt_q;
    logic [`AXI_ADDR_W-1:0]  beat_addr;
    logic [`AXI_ADDR_W-1:0]  conf_ofs;
    logic [`AXI_ADDR_W-1:0]  wst_ofs;
    logic                    conf_hit;
    logic                    wst_hit;
    logic [WST_IDX_W-1:0]    wst_idx;
    logic [`WST_FIFO_NUM-1:0] fifo_full;
    logic [`WST_FIFO_NUM-1:0] fifo_push;
    logic                    w_hsk;

    // FIXED keeps the burst address on every beat
    assign beat_addr = (aw_i.burst == BURST_INCR) ?
                       aw_i.addr + `AXI_ADDR_W'(beat_cnt_q) : aw_i.addr;
    assign conf_ofs  = beat_addr - `CONF_BASE;
    assign wst_ofs   = beat_addr - `WST_BASE;
    assign conf_hit  = conf_ofs < `AXI_ADDR_W'(`CONF_REG_NUM);
    assign wst_hit   = wst_ofs < `AXI_ADDR_W'(`WST_FIFO_NUM);
    assign wst_idx   = wst_ofs[WST_IDX_W-1:0];

    // Full target FIFO holds W, last beat waits for a free B slot
    assign w_ready_o  = aw_valid_i & ~(wst_hit & fifo_full[wst_idx]) &
                        (~w_i.last | ~b_valid_o | b_ready_i);
    assign w_hsk      = w_valid_i & w_ready_o;
    assign aw_ready_o = w_hsk & w_i.last;    // Pop AW with the last beat

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt_q <= '0;
            b_valid_o  <= 1'b0;
            conf_reg_o <= '0;
        end else begin
            if (w_hsk) begin
                beat_cnt_q <= w_i.last ? '0 : beat_cnt_q + 1'b1;
            end
            if (w_hsk && w_i.last) begin
                b_valid_o <= 1'b1;
            end else if (b_ready_i) begin
                b_valid_o <= 1'b0;    // Taken by the B skid buffer
            end
            if (w_hsk && conf_hit) begin
                conf_reg_o[conf_ofs[CONF_IDX_W-1:0]] <= w_i.data;
            end
        end
    end

    // B payload, response follows the last beat's decode
    always_ff @(posedge clk) begin
        if (w_hsk && w_i.last) begin
            b_o.id   <= aw_i.id;
            b_o.resp <= (conf_hit | wst_hit) ? RESP_OKAY : RESP_DECERR;
        end
    end

    for (genvar i = 0; i < `WST_FIFO_NUM; i++) begin : g_wst
        assign fifo_push[i] = w_hsk & wst_hit & (wst_idx == WST_IDX_W'(i));

        wr_stream_fifo #(
            .DEPTH       (`WST_FIFO_DEPTH)
        ) u_fifo (
            .clk         (clk),
            .rst_n       (rst_n),
            .push_i      (fifo_push[i]),
            .push_data_i (w_i.data),
            .full_o      (fifo_full[i]),
            .pop_data_o  (wst_data_o[i]),
            .pop_valid_o (wst_valid_o[i]),
            .pop_ready_i (wst_ready_i[i]),
            .count_o     (wst_count_o[i])
        );
    end

endmodule

`default_nettype wire

/* hw/axi_read_path.sv */
// Read path: beat addressing, region data select and R beat generation
`timescale 1ns/10ps
`default_nettype none
`include "axi_ctrl_settings.svh"

module axi_read_path (
    input  wire                                             clk,
    input  wire                                             rst_n,
    input  wire axi_ctrl_pkg::ar_req_t                      ar_i,
    input  wire                                             ar_valid_i,
    output logic                                            ar_ready_o,
    output axi_ctrl_pkg::r_beat_t                           r_o,
    output logic                                            r_valid_o,
    input  wire                                             r_ready_i,
    input  wire [`CONF_REG_NUM-1:0][`AXI_DATA_W-1:0]        conf_reg_i,
    input  wire [`STAT_REG_NUM-1:0][`AXI_DATA_W-1:0]        stat_reg_i,
    input  wire [`WST_FIFO_NUM-1:0][$clog2(`WST_FIFO_DEPTH):0] wst_count_i
);
    import axi_ctrl_pkg::*;

    localparam int CONF_IDX_W = $clog2(`CONF_REG_NUM);
    localparam int STAT_IDX_W = $clog2(`STAT_REG_NUM);
    localparam int WST_IDX_W  = $clog2(`WST_FIFO_NUM);

    logic [`AXI_LEN_W-1:0]  beat_cnt_q;
    logic [`AXI_ADDR_W-1:0] beat_addr;
    logic [`AXI_ADDR_W-1:0] conf_ofs;
    logic [`AXI_ADDR_W-1:0] stat_ofs;
    logic [`AXI_ADDR_W-1:0] wst_ofs;
    logic                   conf_hit;
    logic                   stat_hit;
    logic                   wst_hit;
    logic                   r_last;
    logic                   r_hsk;
    logic [`AXI_DATA_W-1:0] r_data;

    assign beat_addr = (ar_i.burst == BURST_INCR) ?
                       ar_i.addr + `AXI_ADDR_W'(beat_cnt_q) : ar_i.addr;
    assign conf_ofs  = beat_addr - `CONF_BASE;
    assign stat_ofs  = beat_addr - `STAT_BASE;
    assign wst_ofs   = beat_addr - `WST_BASE;
    assign conf_hit  = conf_ofs < `AXI_ADDR_W'(`CONF_REG_NUM);
    assign stat_hit  = stat_ofs < `AXI_ADDR_W'(`STAT_REG_NUM);
    assign wst_hit   = wst_ofs < `AXI_ADDR_W'(`WST_FIFO_NUM);

    // Regions never overlap, order only picks the mux shape
    always_comb begin
        r_data = '0;    // Unmapped beat reads zero
        if (conf_hit) begin
            r_data = conf_reg_i[conf_ofs[CONF_IDX_W-1:0]];
        end else if (stat_hit) begin
            r_data = stat_reg_i[stat_ofs[STAT_IDX_W-1:0]];
        end else if (wst_hit) begin
            r_data = `AXI_DATA_W'(wst_count_i[wst_ofs[WST_IDX_W-1:0]]);    // Fill level, no pop
        end
    end

    assign r_last     = (beat_cnt_q == ar_i.len);
    assign r_valid_o  = ar_valid_i;    // One beat per cycle
    assign r_hsk      = r_valid_o & r_ready_i;
    assign ar_ready_o = r_hsk & r_last;

    assign r_o = '{id:   ar_i.id,
                   data: r_data,
                   resp: (conf_hit | stat_hit | wst_hit) ? RESP_OKAY : RESP_DECERR,
                   last: r_last};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt_q <= '0;
        end else if (r_hsk) begin
            beat_cnt_q <= r_last ? '0 : beat_cnt_q + 1'b1;    // Restart for next AR
        end
    end

endmodule

`default_nettype wire

/* hw/axi_ctrl_top.sv */
// AXI4 slave register controller, skid buffers around the write and read paths
`timescale 1ns/10ps
`default_nettype none
`include "axi_ctrl_settings.svh"

module axi_ctrl_top (
    input  wire                                    clk,
    input  wire                                    rst_n,
    input  wire  [`AXI_ID_W-1:0]                   m_awid_i,
    input  wire  [`AXI_ADDR_W-1:0]                 m_awaddr_i,
    input  wire  [1:0]                             m_awburst_i,
    input  wire                                    m_awvalid_i,
    output logic                                   m_awready_o,
    input  wire  [`AXI_DATA_W-1:0]                 m_wdata_i,
    input  wire                                    m_wlast_i,
    input  wire                                    m_wvalid_i,
    output logic                                   m_wready_o,
    output logic [`AXI_ID_W-1:0]                   m_bid_o,
    output logic [1:0]                             m_bresp_o,
    output logic                                   m_bvalid_o,
    input  wire                                    m_bready_i,
    input  wire  [`AXI_ID_W-1:0]                   m_arid_i,
    input  wire  [`AXI_ADDR_W-1:0]                 m_araddr_i,
    input  wire  [1:0]                             m_arburst_i,
    input  wire  [`AXI_LEN_W-1:0]                  m_arlen_i,
    input  wire                                    m_arvalid_i,
    output logic                                   m_arready_o,
    output logic [`AXI_ID_W-1:0]                   m_rid_o,
    output logic [`AXI_DATA_W-1:0]                 m_rdata_o,
    output logic [1:0]                             m_rresp_o,
    output logic                                   m_rlast_o,
    output logic                                   m_rvalid_o,
    input  wire                                    m_rready_i,
    input  wire  [`STAT_REG_NUM*`AXI_DATA_W-1:0]   stat_reg_i,    // Byte n at bits 8n+7:8n
    output logic [`CONF_REG_NUM*`AXI_DATA_W-1:0]   conf_reg_o,
    output logic [`WST_FIFO_NUM*`AXI_DATA_W-1:0]   wst_data_o,
    output logic [`WST_FIFO_NUM-1:0]               wst_valid_o,
    input  wire  [`WST_FIFO_NUM-1:0]               wst_ready_i
);
    axi_ctrl_pkg::aw_req_t aw_in, aw_out;
    axi_ctrl_pkg::w_beat_t w_in, w_out;
    axi_ctrl_pkg::ar_req_t ar_in, ar_out;
    axi_ctrl_pkg::b_resp_t b_in, b_out;
    axi_ctrl_pkg::r_beat_t r_in, r_out;
    logic aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
    logic b_valid, b_ready, r_valid, r_ready;
    logic [`WST_FIFO_NUM-1:0][$clog2(`WST_FIFO_DEPTH):0] wst_count;    // Write path to read path

    assign aw_in = '{id: m_awid_i, addr: m_awaddr_i,
                     burst: axi_ctrl_pkg::burst_e'(m_awburst_i)};
    assign w_in  = '{data: m_wdata_i, last: m_wlast_i};
    assign ar_in = '{id: m_arid_i, addr: m_araddr_i,
                     burst: axi_ctrl_pkg::burst_e'(m_arburst_i), len: m_arlen_i};
    assign {m_bid_o, m_bresp_o}                       = b_out;
    assign {m_rid_o, m_rdata_o, m_rresp_o, m_rlast_o} = r_out;

    chan_skid_buf #(.payload_t(axi_ctrl_pkg::aw_req_t)) aw_buf (
        .clk(clk), .rst_n(rst_n),
        .in_data_i(aw_in), .in_valid_i(m_awvalid_i), .in_ready_o(m_awready_o),
        .out_data_o(aw_out), .out_valid_o(aw_valid), .out_ready_i(aw_ready));
    chan_skid_buf #(.payload_t(axi_ctrl_pkg::w_beat_t)) w_buf (
        .clk(clk), .rst_n(rst_n),
        .in_data_i(w_in), .in_valid_i(m_wvalid_i), .in_ready_o(m_wready_o),
        .out_data_o(w_out), .out_valid_o(w_valid), .out_ready_i(w_ready));
    chan_skid_buf #(.payload_t(axi_ctrl_pkg::ar_req_t)) ar_buf (
        .clk(clk), .rst_n(rst_n),
        .in_data_i(ar_in), .in_valid_i(m_arvalid_i), .in_ready_o(m_arready_o),
        .out_data_o(ar_out), .out_valid_o(ar_valid), .out_ready_i(ar_ready));
    chan_skid_buf #(.payload_t(axi_ctrl_pkg::b_resp_t)) b_buf (
        .clk(clk), .rst_n(rst_n),
        .in_data_i(b_in), .in_valid_i(b_valid), .in_ready_o(b_ready),
        .out_data_o(b_out), .out_valid_o(m_bvalid_o), .out_ready_i(m_bready_i));
    chan_skid_buf #(.payload_t(axi_ctrl_pkg::r_beat_t)) r_buf (
        .clk(clk), .rst_n(rst_n),
        .in_data_i(r_in), .in_valid_i(r_valid), .in_ready_o(r_ready),
        .out_data_o(r_out), .out_valid_o(m_rvalid_o), .out_ready_i(m_rready_i));

    axi_write_path u_wr (
        .clk(clk), .rst_n(rst_n),
        .aw_i(aw_out), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_i(w_out), .w_valid_i(w_valid), .w_ready_o(w_ready),
        .b_o(b_in), .b_valid_o(b_valid), .b_ready_i(b_ready),
        .conf_reg_o(conf_reg_o), .wst_count_o(wst_count),
        .wst_data_o(wst_data_o), .wst_valid_o(wst_valid_o), .wst_ready_i(wst_ready_i));

    axi_read_path u_rd (
        .clk(clk), .rst_n(rst_n),
        .ar_i(ar_out), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .r_o(r_in), .r_valid_o(r_valid), .r_ready_i(r_ready),
        .conf_reg_i(conf_reg_o), .stat_reg_i(stat_reg_i), .wst_count_i(wst_count));

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
// Testbench clock source with a fixed 8 ns period
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter realtime HALF_PERIOD = 4.0    // Half of 8 ns
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* sim/axi_ctrl_asserts.sv */
// Handshake checks on the controller's B, R and stream outputs
`timescale 1ns/10ps
`default_nettype none
`include "axi_ctrl_settings.svh"

module axi_ctrl_asserts (
    input wire                                 clk,
    input wire                                 rst_n,
    input wire                                 bvalid_i,
    input wire                                 bready_i,
    input wire [`AXI_ID_W+1:0]                 b_payload_i,    // {bid, bresp}
    input wire                                 rvalid_i,
    input wire                                 rready_i,
    input wire [`AXI_ID_W+`AXI_DATA_W+2:0]     r_payload_i,    // {rid, rdata, rresp, rlast}
    input wire [`WST_FIFO_NUM-1:0]             wst_valid_i,
    input wire [`WST_FIFO_NUM-1:0]             wst_ready_i,
    input wire [2:0]                           ready_i         // {awready, wready, arready}
);
    // B held with stable payload until taken
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_i && !bready_i |=> bvalid_i && $stable(b_payload_i))
        else $error("B valid dropped or payload changed before bready");

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_i && !rready_i |=> rvalid_i && $stable(r_payload_i))
        else $error("R valid dropped or payload changed before rready");

    for (genvar i = 0; i < `WST_FIFO_NUM; i++) begin : g_wst
        wst_hold: assert property (@(posedge clk) disable iff (!rst_n)
            wst_valid_i[i] && !wst_ready_i[i] |=> wst_valid_i[i])
            else $error("Stream valid dropped before the consumer took the byte");
    end

    // Handshake outputs always known once out of reset
    no_x: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({ready_i, bvalid_i, rvalid_i, wst_valid_i}))
        else $error("Unknown value on a ready or valid output");

endmodule

`default_nettype wire

/* sim/axi_ctrl_tb.sv */
// Testbench for the AXI4 register controller, LFSR bursts checked against a model
`timescale 1ns/10ps
`default_nettype none
`include "axi_ctrl_settings.svh"

module axi_ctrl_tb;
    localparam int          ROUNDS           = 25;
    localparam int          BURSTS_PER_ROUND = 10;
    localparam int          BURST_CYCLES     = 300;    // Generous bound per burst
    localparam int          CLK_NS           = 8;
    localparam logic [31:0] SEED             = 32'h2195_3ef1;
    localparam int          R_NONE           = 0;
    localparam int          R_CONF           = 1;
    localparam int          R_STAT           = 2;
    localparam int          R_WST            = 3;

    logic                                 clk;
    logic                                 rst_n;
    logic [`AXI_ID_W-1:0]                 m_awid_i;
    logic [`AXI_ADDR_W-1:0]               m_awaddr_i;
    logic [1:0]                           m_awburst_i;
    logic                                 m_awvalid_i;
    logic                                 m_awready_o;
    logic [`AXI_DATA_W-1:0]               m_wdata_i;
    logic                                 m_wlast_i;
    logic                                 m_wvalid_i;
    logic                                 m_wready_o;
    logic [`AXI_ID_W-1:0]                 m_bid_o;
    logic [1:0]                           m_bresp_o;
    logic                                 m_bvalid_o;
    logic                                 m_bready_i;
    logic [`AXI_ID_W-1:0]                 m_arid_i;
    logic [`AXI_ADDR_W-1:0]               m_araddr_i;
    logic [1:0]                           m_arburst_i;
    logic [`AXI_LEN_W-1:0]                m_arlen_i;
    logic                                 m_arvalid_i;
    logic                                 m_arready_o;
    logic [`AXI_ID_W-1:0]                 m_rid_o;
    logic [`AXI_DATA_W-1:0]               m_rdata_o;
    logic [1:0]                           m_rresp_o;
    logic                                 m_rlast_o;
    logic                                 m_rvalid_o;
    logic                                 m_rready_i;
    logic [`STAT_REG_NUM*`AXI_DATA_W-1:0] stat_reg_i;
    logic [`CONF_REG_NUM*`AXI_DATA_W-1:0] conf_reg_o;
    logic [`WST_FIFO_NUM*`AXI_DATA_W-1:0] wst_data_o;
    logic [`WST_FIFO_NUM-1:0]             wst_valid_o;
    logic [`WST_FIFO_NUM-1:0]             wst_ready_i;

    // Reference model
    logic [7:0]                           conf_model [`CONF_REG_NUM];
    logic [`STAT_REG_NUM*8-1:0]           stat_model;
    logic [7:0]                           wst_q [`WST_FIFO_NUM][$];    // Bytes not yet drained
    logic [31:0]                          stim_lfsr = SEED;
    logic [4:0]                           burst_id  = '0;
    logic                                 hold_wst;                    // Freeze the consumer

    tb_clk_gen clk_src (.clk_o(clk));

    axi_ctrl_top uut (.*);

    bind axi_ctrl_top axi_ctrl_asserts u_asserts (
        .clk         (clk),
        .rst_n       (rst_n),
        .bvalid_i    (m_bvalid_o),
        .bready_i    (m_bready_i),
        .b_payload_i ({m_bid_o, m_bresp_o}),
        .rvalid_i    (m_rvalid_o),
        .rready_i    (m_rready_i),
        .r_payload_i ({m_rid_o, m_rdata_o, m_rresp_o, m_rlast_o}),
        .wst_valid_i (wst_valid_o),
        .wst_ready_i (wst_ready_i),
        .ready_i     ({m_awready_o, m_wready_o, m_arready_o})
    );

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            stim_lfsr = lfsr_step(stim_lfsr);    // One step per bit
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    task automatic check(input logic [63:0] exp, input logic [63:0] act, input string msg);
        if (exp !== act) begin
            $display("Mismatch at %0d ns: %s, expected %0h, got %0h", $time, msg, exp, act);
            $display("TB FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic logic [31:0] beat_addr(input logic [31:0] base, input logic [1:0] burst,
                                              input int beat);
        return (burst == 2'b01) ? base + beat : base;    // FIXED repeats the base
    endfunction

    function automatic int region_of(input logic [31:0] a);
        if (a >= `CONF_BASE && a < `CONF_BASE + `CONF_REG_NUM) begin
            return R_CONF;
        end
        if (a >= `STAT_BASE && a < `STAT_BASE + `STAT_REG_NUM) begin
            return R_STAT;
        end
        if (a >= `WST_BASE && a < `WST_BASE + `WST_FIFO_NUM) begin
            return R_WST;
        end
        return R_NONE;
    endfunction

    function automatic logic [1:0] exp_resp(input logic [31:0] a, input logic is_wr);
        case (region_of(a))
            R_CONF, R_WST: return 2'b00;
            R_STAT:        return is_wr ? 2'b11 : 2'b00;    // Status is read-only
            default:       return 2'b11;
        endcase
    endfunction

    function automatic logic [7:0] exp_rdata(input logic [31:0] a);
        case (region_of(a))
            R_CONF:  return conf_model[int'(a - `CONF_BASE)];
            R_STAT:  return stat_model[int'(a - `STAT_BASE) * 8 +: 8];
            R_WST:   return 8'(wst_q[int'(a - `WST_BASE)].size());    // Fill count
            default: return 8'h00;
        endcase
    endfunction

    task automatic check_conf();
        logic [`CONF_REG_NUM*8-1:0] exp;
        for (int k = 0; k < `CONF_REG_NUM; k++) begin
            exp[k*8 +: 8] = conf_model[k];
        end
        check(exp, conf_reg_o, "conf_reg_o after B");
    endtask

    task automatic write_burst(input logic [31:0] addr, input logic [1:0] burst, input int len);
        logic [31:0] a;
        logic [7:0]  d;
        burst_id++;
        m_awid_i    <= burst_id;
        m_awaddr_i  <= addr;
        m_awburst_i <= burst;
        m_awvalid_i <= 1'b1;
        @(posedge clk);
        while (!m_awready_o) @(posedge clk);
        m_awvalid_i <= 1'b0;
        for (int b = 0; b <= len; b++) begin
            a = beat_addr(addr, burst, b);
            d = 8'(rand_bits(8));
            m_wdata_i  <= d;
            m_wlast_i  <= (b == len);
            m_wvalid_i <= 1'b1;
            @(posedge clk);
            while (!m_wready_o) @(posedge clk);
            case (region_of(a))
                R_CONF:  conf_model[int'(a - `CONF_BASE)] = d;
                R_WST:   wst_q[int'(a - `WST_BASE)].push_back(d);
                default: ;    // Status and unmapped writes drop
            endcase
        end
        m_wvalid_i <= 1'b0;
        @(posedge clk);
        while (!(m_bvalid_o && m_bready_i)) @(posedge clk);
        check(burst_id, m_bid_o, "bid");
        check(exp_resp(a, 1'b1), m_bresp_o, "bresp");    // Last beat decides
        check_conf();
    endtask

    task automatic read_burst(input logic [31:0] addr, input logic [1:0] burst, input int len);
        logic [31:0] a;
        int          beat;
        hold_wst <= 1'b1;
        repeat (3) @(posedge clk);    // Let in-flight pops settle
        burst_id++;
        m_arid_i    <= burst_id;
        m_araddr_i  <= addr;
        m_arburst_i <= burst;
        m_arlen_i   <= 8'(len);
        m_arvalid_i <= 1'b1;
        @(posedge clk);
        while (!m_arready_o) @(posedge clk);
        m_arvalid_i <= 1'b0;
        beat = 0;
        while (beat <= len) begin
            @(posedge clk);
            if (m_rvalid_o && m_rready_i) begin
                a = beat_addr(addr, burst, beat);
                check(burst_id, m_rid_o, "rid");
                check(exp_rdata(a), m_rdata_o, "rdata");
                check(exp_resp(a, 1'b0), m_rresp_o, "rresp");
                check(beat == len, m_rlast_o, "rlast");
                beat++;
            end
        end
        hold_wst <= 1'b0;
    endtask

    task automatic run_round();
        int          off;
        logic [31:0] base;
        logic [1:0]  burst;
        off = rand_bits(3);
        write_burst(`CONF_BASE + off, 2'b01, rand_bits(3) % (8 - off));    // Stays in region
        read_burst(`CONF_BASE, 2'b01, 7);
        off = rand_bits(3);
        write_burst(`CONF_BASE + off, 2'b00, rand_bits(3));    // Only the last beat sticks
        read_burst(`CONF_BASE + off, 2'b00, rand_bits(3));
        stat_model[63:32] = rand_bits(32);
        stat_model[31:0]  = rand_bits(32);
        stat_reg_i <= stat_model;
        read_burst(`STAT_BASE, 2'b01, 7);
        write_burst(`STAT_BASE + rand_bits(2), 2'b01, rand_bits(2));    // Expect DECERR
        write_burst(`WST_BASE + rand_bits(1), 2'b00, rand_bits(3));
        read_burst(`WST_BASE, 2'b01, 1);    // Both fill counts
        base  = rand_bits(1) ? `CONF_BASE + 8 : `WST_BASE + 2;    // Just past a region
        base  = base + rand_bits(16);
        burst = 2'(rand_bits(1));
        write_burst(base, burst, rand_bits(3));
        read_burst(base, burst, rand_bits(3));
    endtask

    // Random back-pressure and the stream consumer
    initial begin : consumer
        logic [3:0]  bits;
        logic [31:0] bp_lfsr;
        bp_lfsr     = SEED;
        m_bready_i  = 1'b0;
        m_rready_i  = 1'b0;
        wst_ready_i = '0;
        forever begin
            @(posedge clk);
            for (int i = 0; i < `WST_FIFO_NUM; i++) begin
                if (rst_n && wst_valid_o[i] && wst_ready_i[i]) begin
                    check(1, wst_q[i].size() != 0, "stream byte with empty model queue");
                    check(wst_q[i].pop_front(), wst_data_o[i*8 +: 8], "stream data order");
                end
            end
            for (int k = 0; k < 4; k++) begin
                bp_lfsr = lfsr_step(bp_lfsr);
                bits[k] = bp_lfsr[0];
            end
            m_bready_i  <= bits[0];
            m_rready_i  <= bits[1];
            wst_ready_i <= hold_wst ? '0 : bits[3:2];
        end
    end

    initial begin
        #(ROUNDS * BURSTS_PER_ROUND * BURST_CYCLES * CLK_NS);
        $display("Timeout: bursts or stream bytes did not complete in time");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n       = 1'b0;
        m_awid_i    = '0;
        m_awaddr_i  = '0;
        m_awburst_i = '0;
        m_awvalid_i = 1'b0;
        m_wdata_i   = '0;
        m_wlast_i   = 1'b0;
        m_wvalid_i  = 1'b0;
        m_arid_i    = '0;
        m_araddr_i  = '0;
        m_arburst_i = '0;
        m_arlen_i   = '0;
        m_arvalid_i = 1'b0;
        stat_reg_i  = '0;
        stat_model  = '0;
        hold_wst    = 1'b0;
        conf_model  = '{default: 8'h00};
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int n = 0; n < ROUNDS; n++) begin
            run_round();
        end
        while (wst_q[0].size() + wst_q[1].size() != 0) @(posedge clk);    // Drain streams
        repeat (20) @(posedge clk);
        check(0, m_bvalid_o, "stray bvalid after last burst");
        check(0, m_rvalid_o, "stray rvalid after last burst");
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+hw
hw/axi_ctrl_pkg.sv
hw/chan_skid_buf.sv
hw/wr_stream_fifo.sv
hw/axi_write_path.sv
hw/axi_read_path.sv
hw/axi_ctrl_top.sv
sim/tb_clk_gen.sv
sim/axi_ctrl_asserts.sv
sim/axi_ctrl_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module axi_ctrl_tb -o axi_ctrl_sim
	./obj_dir/axi_ctrl_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
